// ==== llc_pkg.sv ====
// *******************************************************************
// LLC shared types and geometry
// *******************************************************************

`default_nettype none

package llc_pkg;

    // address and line widths, a line is one word
    localparam int llc_addr_w = 16;
    localparam int llc_data_w = 32;

    // default geometry, the top level passes these down
    localparam int llc_ways_default = 4;
    localparam int llc_sets_default = 16;

    typedef logic [llc_data_w-1:0] llc_data_t;
    typedef logic [llc_addr_w-1:0] llc_addr_t;

    // per-line state kept in the state array
    typedef enum logic [1:0] {
        state_invalid = 2'b00,
        state_valid   = 2'b01,
        state_dirty   = 2'b10
    } llc_state_t;

    // request from the requester, 49 bits
    typedef struct packed {
        logic      write;
        llc_addr_t addr;
        llc_data_t data;
    } llc_req_t;

    // read data returned by main memory
    typedef struct packed {
        llc_data_t data;
    } llc_mem_rsp_t;

    // controller states
    typedef enum logic [2:0] {
        fsm_read_set,
        fsm_lookup,
        fsm_process,
        fsm_writeback,
        fsm_fill,
        fsm_respond
    } llc_fsm_t;

endpackage

`default_nettype wire

// ==== llc_mem_if.sv ====
// *******************************************************************
// LLC array access bus
// *******************************************************************

`timescale 1ns/1ps
`default_nettype none

interface llc_mem_if
    import llc_pkg::*;
#(
    parameter int num_ways = llc_ways_default,
    parameter int num_sets = llc_sets_default
) ();
    localparam int set_w = $clog2(num_sets);
    localparam int tag_w = llc_addr_w - set_w;
    localparam int way_w = (num_ways > 1) ? $clog2(num_ways) : 1;

    // read request and write port, one set at a time
    logic                 rd_en;
    logic [set_w-1:0]     set;
    logic                 wr_en;
    logic [way_w-1:0]     wr_way;
    logic [tag_w-1:0]     wr_tag;
    llc_state_t           wr_state;
    llc_data_t            wr_data;
    logic                 adv_evict;

    // registered read results, valid the cycle after rd_en
    logic [num_ways-1:0][tag_w-1:0] rd_tags;
    llc_state_t [num_ways-1:0]      rd_states;
    llc_data_t [num_ways-1:0]       rd_data;
    logic [way_w-1:0]               evict_way;

    modport ctrl (
        output rd_en, set, wr_en, wr_way, wr_tag, wr_state, wr_data, adv_evict,
        input  rd_tags, rd_states, rd_data, evict_way
    );

    modport mem (
        input  rd_en, set, wr_en, wr_way, wr_tag, wr_state, wr_data, adv_evict,
        output rd_tags, rd_states, rd_data, evict_way
    );

endinterface

`default_nettype wire

// ==== llc_fifo.sv ====
// *******************************************************************
// Small synchronous FIFO
// *******************************************************************

`timescale 1ns/1ps
`default_nettype none

module llc_fifo #(
    parameter int  depth     = 2,
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push_i,
    input  payload_t data_i,
    output logic     full_o,
    input  logic     pop_i,
    output payload_t data_o,
    output logic     empty_o
);
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t         buf_mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign full_o  = (count == cnt_w'(depth));
    assign empty_o = (count == '0);
    // full push is dropped, upstream ready already low
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;
    assign data_o  = buf_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            buf_mem[wr_ptr] <= data_i;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== llc_localmem.sv ====
// *******************************************************************
// LLC tag, state and data arrays
// *******************************************************************

`timescale 1ns/1ps
`default_nettype none

module llc_localmem
    import llc_pkg::*;
#(
    parameter int num_ways = llc_ways_default,
    parameter int num_sets = llc_sets_default
) (
    input  logic     clk,
    input  logic     rst,
    llc_mem_if.mem   mb
);
    localparam int set_w = $clog2(num_sets);
    localparam int tag_w = llc_addr_w - set_w;
    localparam int way_w = (num_ways > 1) ? $clog2(num_ways) : 1;

    logic [tag_w-1:0] tag_mem   [num_sets][num_ways];
    llc_data_t        data_mem  [num_sets][num_ways];
    llc_state_t       state_mem [num_sets][num_ways];
    // round-robin pointer per set
    logic [way_w-1:0] evict_mem [num_sets];
    logic [way_w-1:0] evict_next;

    assign evict_next = (evict_mem[mb.set] == way_w'(num_ways - 1)) ?
                        '0 : evict_mem[mb.set] + 1'b1;

    // tags and data, plus their read registers
    always_ff @(posedge clk) begin
        if (mb.wr_en) begin
            tag_mem[mb.set][mb.wr_way]  <= mb.wr_tag;
            data_mem[mb.set][mb.wr_way] <= mb.wr_data;
        end
        if (mb.rd_en) begin
            for (int w = 0; w < num_ways; w++) begin
                mb.rd_tags[w] <= tag_mem[mb.set][w];
                mb.rd_data[w] <= data_mem[mb.set][w];
            end
        end
    end

    // line states and evict pointers start cleared
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < num_sets; s++) begin
                for (int w = 0; w < num_ways; w++) begin
                    state_mem[s][w] <= state_invalid;
                end
                evict_mem[s] <= '0;
            end
            for (int w = 0; w < num_ways; w++) begin
                mb.rd_states[w] <= state_invalid;
            end
            mb.evict_way <= '0;
        end else begin
            if (mb.wr_en) begin
                state_mem[mb.set][mb.wr_way] <= mb.wr_state;
            end
            if (mb.adv_evict) begin
                evict_mem[mb.set] <= evict_next;
            end
            if (mb.rd_en) begin
                for (int w = 0; w < num_ways; w++) begin
                    mb.rd_states[w] <= state_mem[mb.set][w];
                end
                mb.evict_way <= evict_mem[mb.set];
            end
        end
    end

endmodule

`default_nettype wire

// ==== llc_lookup_way.sv ====
// *******************************************************************
// LLC hit and victim selection
// *******************************************************************

`timescale 1ns/1ps
`default_nettype none

module llc_lookup_way
    import llc_pkg::*;
#(
    parameter int num_ways = llc_ways_default,
    parameter int num_sets = llc_sets_default,
    localparam int set_w = $clog2(num_sets),
    localparam int tag_w = llc_addr_w - set_w,
    localparam int way_w = (num_ways > 1) ? $clog2(num_ways) : 1
) (
    input  logic [tag_w-1:0]                tag_i,
    input  logic [num_ways-1:0][tag_w-1:0]  rd_tags_i,
    input  llc_state_t [num_ways-1:0]       rd_states_i,
    input  logic [way_w-1:0]                evict_way_i,
    output logic                            hit_o,
    output logic [way_w-1:0]                hit_way_o,
    output logic [way_w-1:0]                victim_way_o,
    output logic                            victim_dirty_o,
    output logic [tag_w-1:0]                victim_tag_o
);

    // walk down so the lowest invalid way wins
    always_comb begin
        hit_o        = 1'b0;
        hit_way_o    = '0;
        victim_way_o = evict_way_i;
        for (int w = num_ways - 1; w >= 0; w--) begin
            if (rd_states_i[w] != state_invalid && rd_tags_i[w] == tag_i) begin
                hit_o     = 1'b1;
                hit_way_o = way_w'(w);
            end
            if (rd_states_i[w] == state_invalid) begin
                victim_way_o = way_w'(w);
            end
        end
    end

    // needed for the writeback address
    assign victim_dirty_o = (rd_states_i[victim_way_o] == state_dirty);
    assign victim_tag_o   = rd_tags_i[victim_way_o];

endmodule

`default_nettype wire

// ==== llc_ctrl.sv ====
// *******************************************************************
// LLC request controller
// *******************************************************************

`timescale 1ns/1ps
`default_nettype none

module llc_ctrl
    import llc_pkg::*;
#(
    parameter int num_ways = llc_ways_default,
    parameter int num_sets = llc_sets_default,
    localparam int set_w = $clog2(num_sets),
    localparam int tag_w = llc_addr_w - set_w,
    localparam int way_w = (num_ways > 1) ? $clog2(num_ways) : 1
) (
    input  logic              clk,
    input  logic              rst,
    input  llc_req_t          req_i,
    input  logic              req_empty_i,
    output logic              req_pop_o,
    input  llc_mem_rsp_t      mem_rsp_i,
    input  logic              mem_rsp_empty_i,
    output logic              mem_rsp_pop_o,
    llc_mem_if.ctrl           mb,
    input  logic              hit_i,
    input  logic [way_w-1:0]  hit_way_i,
    input  logic [way_w-1:0]  victim_way_i,
    input  logic              victim_dirty_i,
    input  logic [tag_w-1:0]  victim_tag_i,
    output logic [tag_w-1:0]  tag_o,
    output logic              rsp_valid_o,
    output llc_data_t         rsp_data_o,
    output logic              rsp_hit_o,
    input  logic              rsp_ready_i,
    output logic              mem_req_valid_o,
    output logic              mem_req_write_o,
    output llc_addr_t         mem_req_addr_o,
    output llc_data_t         mem_req_data_o,
    input  logic              mem_req_ready_i
);
    llc_fsm_t         state_q;
    llc_fsm_t         state_d;
    llc_req_t         req_q;
    logic             hit_q;
    logic             dirty_q;
    // victim taken from the round-robin pointer
    logic             evict_q;
    // fill read already accepted by memory
    logic             sent_q;
    logic [way_w-1:0] way_q;
    logic [tag_w-1:0] vtag_q;
    llc_data_t        rsp_data_q;

    assign tag_o     = req_q.addr[llc_addr_w-1 -: tag_w];
    assign mb.set    = (state_q == fsm_read_set) ? req_i.addr[set_w-1:0] : req_q.addr[set_w-1:0];
    assign mb.wr_way = way_q;
    assign mb.wr_tag = tag_o;
    assign mb.wr_state = req_q.write ? state_dirty : state_valid;
    // read miss installs memory data, everything else the request data
    assign mb.wr_data = (state_q == fsm_fill && !req_q.write) ? mem_rsp_i.data : req_q.data;

    assign rsp_valid_o = (state_q == fsm_respond);
    assign rsp_data_o  = rsp_data_q;
    assign rsp_hit_o   = hit_q;

    always_comb begin
        state_d         = state_q;
        req_pop_o       = 1'b0;
        mem_rsp_pop_o   = 1'b0;
        mb.rd_en        = 1'b0;
        mb.wr_en        = 1'b0;
        mb.adv_evict    = 1'b0;
        mem_req_valid_o = 1'b0;
        mem_req_write_o = 1'b0;
        mem_req_addr_o  = req_q.addr;
        mem_req_data_o  = req_q.data;
        case (state_q)
            fsm_read_set: begin
                if (!req_empty_i) begin
                    mb.rd_en = 1'b1;
                    state_d  = fsm_lookup;
                end
            end
            fsm_lookup: state_d = fsm_process;
            fsm_process: begin
                if (hit_q) begin
                    mb.wr_en  = req_q.write;
                    req_pop_o = 1'b1;
                    state_d   = fsm_respond;
                end else begin
                    state_d = dirty_q ? fsm_writeback : fsm_fill;
                end
            end
            fsm_writeback: begin
                mem_req_valid_o = 1'b1;
                mem_req_write_o = 1'b1;
                mem_req_addr_o  = {vtag_q, req_q.addr[set_w-1:0]};
                mem_req_data_o  = mb.rd_data[way_q];
                if (mem_req_ready_i) begin
                    state_d = fsm_fill;
                end
            end
            fsm_fill: begin
                mem_req_valid_o = !sent_q;
                if (sent_q && !mem_rsp_empty_i) begin
                    mb.wr_en      = 1'b1;
                    mb.adv_evict  = evict_q;
                    mem_rsp_pop_o = 1'b1;
                    req_pop_o     = 1'b1;
                    state_d       = fsm_respond;
                end
            end
            fsm_respond: begin
                if (rsp_ready_i) begin
                    state_d = fsm_read_set;
                end
            end
            default: state_d = fsm_read_set;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q <= fsm_read_set;
            hit_q   <= 1'b0;
            dirty_q <= 1'b0;
            evict_q <= 1'b0;
            sent_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == fsm_lookup) begin
                hit_q   <= hit_i;
                dirty_q <= !hit_i && victim_dirty_i;
                evict_q <= !hit_i && (mb.rd_states[victim_way_i] != state_invalid);
            end
            if (state_q != fsm_fill) begin
                sent_q <= 1'b0;
            end else if (mem_req_valid_o && mem_req_ready_i) begin
                sent_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == fsm_read_set && !req_empty_i) begin
            req_q <= req_i;
        end
        if (state_q == fsm_lookup) begin
            way_q  <= hit_i ? hit_way_i : victim_way_i;
            vtag_q <= victim_tag_i;
        end
        if (state_q == fsm_process && hit_q) begin
            rsp_data_q <= req_q.write ? req_q.data : mb.rd_data[way_q];
        end else if (state_q == fsm_fill && mb.wr_en) begin
            rsp_data_q <= mb.wr_data;
        end
    end

endmodule

`default_nettype wire

// ==== llc_core.sv ====
// *******************************************************************
// LLC core top level
// *******************************************************************

`timescale 1ns/1ps
`default_nettype none

module llc_core
    import llc_pkg::*;
#(
    parameter int num_ways = llc_ways_default,
    parameter int num_sets = llc_sets_default
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      req_valid_i,
    input  logic      req_write_i,
    input  llc_addr_t req_addr_i,
    input  llc_data_t req_data_i,
    output logic      req_ready_o,
    output logic      rsp_valid_o,
    output llc_data_t rsp_data_o,
    output logic      rsp_hit_o,
    input  logic      rsp_ready_i,
    output logic      mem_req_valid_o,
    output logic      mem_req_write_o,
    output llc_addr_t mem_req_addr_o,
    output llc_data_t mem_req_data_o,
    input  logic      mem_req_ready_i,
    input  logic      mem_rsp_valid_i,
    input  llc_data_t mem_rsp_data_i,
    output logic      mem_rsp_ready_o
);
    localparam int set_w = $clog2(num_sets);
    localparam int tag_w = llc_addr_w - set_w;
    localparam int way_w = (num_ways > 1) ? $clog2(num_ways) : 1;

    llc_req_t         req_in;
    llc_req_t         req_head;
    logic             req_full;
    logic             req_empty;
    logic             req_pop;
    llc_mem_rsp_t     mrsp_in;
    llc_mem_rsp_t     mrsp_head;
    logic             mrsp_full;
    logic             mrsp_empty;
    logic             mrsp_pop;
    logic             hit;
    logic [way_w-1:0] hit_way;
    logic [way_w-1:0] victim_way;
    logic             victim_dirty;
    logic [tag_w-1:0] victim_tag;
    logic [tag_w-1:0] tag;

    assign req_in          = '{write: req_write_i, addr: req_addr_i, data: req_data_i};
    assign mrsp_in         = '{data: mem_rsp_data_i};
    assign req_ready_o     = !req_full;
    assign mem_rsp_ready_o = !mrsp_full;

    llc_mem_if #(.num_ways(num_ways), .num_sets(num_sets)) mem_bus ();

    llc_fifo #(.depth(2), .payload_t(llc_req_t)) req_fifo (
        .clk(clk), .rst(rst), .push_i(req_valid_i), .data_i(req_in), .full_o(req_full),
        .pop_i(req_pop), .data_o(req_head), .empty_o(req_empty)
    );

    llc_fifo #(.depth(2), .payload_t(llc_mem_rsp_t)) mem_rsp_fifo (
        .clk(clk), .rst(rst), .push_i(mem_rsp_valid_i), .data_i(mrsp_in), .full_o(mrsp_full),
        .pop_i(mrsp_pop), .data_o(mrsp_head), .empty_o(mrsp_empty)
    );

    llc_localmem #(.num_ways(num_ways), .num_sets(num_sets)) localmem_u (
        .clk(clk), .rst(rst), .mb(mem_bus.mem)
    );

    llc_lookup_way #(.num_ways(num_ways), .num_sets(num_sets)) lookup_way_u (
        .tag_i(tag), .rd_tags_i(mem_bus.rd_tags), .rd_states_i(mem_bus.rd_states),
        .evict_way_i(mem_bus.evict_way), .hit_o(hit), .hit_way_o(hit_way),
        .victim_way_o(victim_way), .victim_dirty_o(victim_dirty), .victim_tag_o(victim_tag)
    );

    llc_ctrl #(.num_ways(num_ways), .num_sets(num_sets)) ctrl_u (
        .clk(clk), .rst(rst),
        .req_i(req_head), .req_empty_i(req_empty), .req_pop_o(req_pop),
        .mem_rsp_i(mrsp_head), .mem_rsp_empty_i(mrsp_empty), .mem_rsp_pop_o(mrsp_pop),
        .mb(mem_bus.ctrl),
        .hit_i(hit), .hit_way_i(hit_way), .victim_way_i(victim_way),
        .victim_dirty_i(victim_dirty), .victim_tag_i(victim_tag), .tag_o(tag),
        .rsp_valid_o(rsp_valid_o), .rsp_data_o(rsp_data_o), .rsp_hit_o(rsp_hit_o),
        .rsp_ready_i(rsp_ready_i),
        .mem_req_valid_o(mem_req_valid_o), .mem_req_write_o(mem_req_write_o),
        .mem_req_addr_o(mem_req_addr_o), .mem_req_data_o(mem_req_data_o),
        .mem_req_ready_i(mem_req_ready_i)
    );

endmodule

`default_nettype wire

// ==== tb_llc.sv ====
// *******************************************************************
// LLC core testbench
// *******************************************************************

`timescale 1ns/1ps
`default_nettype none

module tb_llc
    import llc_pkg::*;
();
    typedef struct packed {
        logic      write;
        llc_addr_t addr;
        llc_data_t data;
        llc_data_t exp_data;
        logic      exp_hit;
    } entry_t;

    logic      clk = 1'b0;
    logic      rst;
    logic      req_valid_i;
    logic      req_write_i;
    llc_addr_t req_addr_i;
    llc_data_t req_data_i;
    logic      req_ready_o;
    logic      rsp_valid_o;
    llc_data_t rsp_data_o;
    logic      rsp_hit_o;
    logic      rsp_ready_i = 1'b0;
    logic      mem_req_valid_o;
    logic      mem_req_write_o;
    llc_addr_t mem_req_addr_o;
    llc_data_t mem_req_data_o;
    logic      mem_req_ready_i = 1'b0;
    logic      mem_rsp_valid_i = 1'b0;
    llc_data_t mem_rsp_data_i = '0;
    logic      mem_rsp_ready_o;

    entry_t      tbl [$];
    // expected memory writes as {addr, data} in order
    logic [47:0] wb_exp [$];
    llc_data_t   written [llc_addr_t];
    logic [15:0] lfsr = 16'd28043;
    int          sent;
    int          rsp_count = 0;
    int          wb_idx = 0;
    int          cycle_cnt = 0;
    int          cycle_limit = 0;
    logic        rd_pending = 1'b0;
    logic [2:0]  rd_delay = 3'd0;
    llc_addr_t   rd_addr = '0;
    logic        rb_hi;
    logic        rb_lo;

    llc_core #(.num_ways(llc_ways_default), .num_sets(llc_sets_default)) UUT (
        .clk(clk), .rst(rst),
        .req_valid_i(req_valid_i), .req_write_i(req_write_i), .req_addr_i(req_addr_i),
        .req_data_i(req_data_i), .req_ready_o(req_ready_o),
        .rsp_valid_o(rsp_valid_o), .rsp_data_o(rsp_data_o), .rsp_hit_o(rsp_hit_o),
        .rsp_ready_i(rsp_ready_i),
        .mem_req_valid_o(mem_req_valid_o), .mem_req_write_o(mem_req_write_o),
        .mem_req_addr_o(mem_req_addr_o), .mem_req_data_o(mem_req_data_o),
        .mem_req_ready_i(mem_req_ready_i),
        .mem_rsp_valid_i(mem_rsp_valid_i), .mem_rsp_data_i(mem_rsp_data_i),
        .mem_rsp_ready_o(mem_rsp_ready_o)
    );

    always #50 clk = ~clk;

    // initial main memory content
    function automatic llc_data_t mem_word(input llc_addr_t a);
        return {16'h0000, a ^ 16'h5A5A} ^ 32'hC0DE0000;
    endfunction

    function automatic llc_data_t mem_read(input llc_addr_t a);
        return written.exists(a) ? written[a] : mem_word(a);
    endfunction

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic random_bit();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    endtask

    task automatic add_entry(input logic w, input llc_addr_t a, input llc_data_t d,
                             input llc_data_t exp, input logic hit);
        tbl.push_back('{write: w, addr: a, data: d, exp_data: exp, exp_hit: hit});
    endtask

    task automatic build_table();
        // cold miss then hit in set 1
        add_entry(1'b0, 16'h0011, 32'h0, mem_word(16'h0011), 1'b0);
        add_entry(1'b0, 16'h0011, 32'h0, mem_word(16'h0011), 1'b1);
        // write allocate in set 2 stays in the cache
        add_entry(1'b1, 16'h0022, 32'hA5A50001, 32'hA5A50001, 1'b0);
        add_entry(1'b0, 16'h0022, 32'h0, 32'hA5A50001, 1'b1);
        // five tags over the four ways of set 3
        add_entry(1'b0, 16'h0013, 32'h0, mem_word(16'h0013), 1'b0);
        add_entry(1'b0, 16'h0023, 32'h0, mem_word(16'h0023), 1'b0);
        add_entry(1'b0, 16'h0033, 32'h0, mem_word(16'h0033), 1'b0);
        add_entry(1'b0, 16'h0043, 32'h0, mem_word(16'h0043), 1'b0);
        add_entry(1'b0, 16'h0053, 32'h0, mem_word(16'h0053), 1'b0);
        add_entry(1'b0, 16'h0013, 32'h0, mem_word(16'h0013), 1'b0);
        add_entry(1'b0, 16'h0053, 32'h0, mem_word(16'h0053), 1'b1);
        add_entry(1'b0, 16'h0033, 32'h0, mem_word(16'h0033), 1'b1);
        add_entry(1'b0, 16'h0023, 32'h0, mem_word(16'h0023), 1'b0);
        // fill the other ways of set 2 and evict the dirty way 0
        add_entry(1'b0, 16'h0122, 32'h0, mem_word(16'h0122), 1'b0);
        add_entry(1'b0, 16'h0222, 32'h0, mem_word(16'h0222), 1'b0);
        add_entry(1'b0, 16'h0322, 32'h0, mem_word(16'h0322), 1'b0);
        add_entry(1'b0, 16'h0422, 32'h0, mem_word(16'h0422), 1'b0);
        wb_exp.push_back({16'h0022, 32'hA5A50001});
        add_entry(1'b0, 16'h0022, 32'h0, 32'hA5A50001, 1'b0);
        add_entry(1'b1, 16'h0422, 32'h12345678, 32'h12345678, 1'b1);
        add_entry(1'b1, 16'h0522, 32'h0BADF00D, 32'h0BADF00D, 1'b0);
        add_entry(1'b0, 16'h0622, 32'h0, mem_word(16'h0622), 1'b0);
        add_entry(1'b0, 16'h0722, 32'h0, mem_word(16'h0722), 1'b0);
        wb_exp.push_back({16'h0422, 32'h12345678});
        add_entry(1'b0, 16'h0422, 32'h0, 32'h12345678, 1'b0);
        add_entry(1'b0, 16'h0522, 32'h0, 32'h0BADF00D, 1'b1);
        add_entry(1'b0, 16'h0011, 32'h0, mem_word(16'h0011), 1'b1);
        add_entry(1'b1, 16'h0000, 32'hFFFF0000, 32'hFFFF0000, 1'b0);
        add_entry(1'b0, 16'h0000, 32'h0, 32'hFFFF0000, 1'b1);
    endtask

    // memory model and random ready
    always @(posedge clk) begin
        if (rst) begin
            rsp_ready_i     <= random_bit() | random_bit();
            mem_req_ready_i <= random_bit() | random_bit();
            if (mem_rsp_valid_i && mem_rsp_ready_o) begin
                mem_rsp_valid_i <= 1'b0;
            end
            if (rd_pending) begin
                rd_delay = rd_delay - 3'd1;
                if (rd_delay == 3'd0) begin
                    mem_rsp_valid_i <= 1'b1;
                    mem_rsp_data_i  <= mem_read(rd_addr);
                    rd_pending = 1'b0;
                end
            end
            if (mem_req_valid_o && mem_req_ready_i) begin
                if (mem_req_write_o) begin
                    if (wb_idx >= wb_exp.size()) begin
                        $display("memory write to %h with no writeback expected",
                                 mem_req_addr_o);
                        $display("FAIL: see errors above");
                        $fatal(1);
                    end else begin
                        check_value("mem_req_addr_o", 32'(mem_req_addr_o),
                                    32'(wb_exp[wb_idx][47:32]));
                        check_value("mem_req_data_o", mem_req_data_o,
                                    wb_exp[wb_idx][31:0]);
                        wb_idx = wb_idx + 1;
                        written[mem_req_addr_o] = mem_req_data_o;
                    end
                end else begin
                    rd_addr = mem_req_addr_o;
                    rb_hi = random_bit();
                    rb_lo = random_bit();
                    // 1 to 4 cycles
                    rd_delay = {1'b0, rb_hi, rb_lo} + 3'd1;
                    rd_pending = 1'b1;
                end
            end
        end
    end

    // responses are checked in table order
    always @(posedge clk) begin
        if (rst && rsp_valid_o && rsp_ready_i) begin
            if (rsp_count >= tbl.size()) begin
                $display("response received with no request outstanding");
                $display("FAIL: see errors above");
                $fatal(1);
            end else begin
                check_value("rsp_data_o", rsp_data_o, tbl[rsp_count].exp_data);
                check_value("rsp_hit_o", 32'(rsp_hit_o), 32'(tbl[rsp_count].exp_hit));
                rsp_count = rsp_count + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt > cycle_limit) begin
            $display("timeout after %0d cycles with %0d of %0d responses",
                     cycle_cnt, rsp_count, tbl.size());
            $display("FAIL: see errors above");
            $fatal(1);
        end
    end

    initial begin
        rst         = 1'b0;
        req_valid_i = 1'b0;
        req_write_i = 1'b0;
        req_addr_i  = '0;
        req_data_i  = '0;
        build_table();
        cycle_limit = tbl.size() * 40;
        repeat (3) @(posedge clk);
        check_value("rsp_valid_o", 32'(rsp_valid_o), 32'h0);
        check_value("mem_req_valid_o", 32'(mem_req_valid_o), 32'h0);
        rst <= 1'b1;
        // valid holds each entry until it is taken
        sent = 0;
        while (sent < tbl.size()) begin
            @(posedge clk);
            if (req_valid_i && req_ready_o) begin
                sent = sent + 1;
            end
            if (sent < tbl.size()) begin
                req_valid_i <= 1'b1;
                req_write_i <= tbl[sent].write;
                req_addr_i  <= tbl[sent].addr;
                req_data_i  <= tbl[sent].data;
            end else begin
                req_valid_i <= 1'b0;
            end
        end
        wait (rsp_count == tbl.size());
        repeat (8) begin
            @(posedge clk);
            check_value("rsp_valid_o", 32'(rsp_valid_o), 32'h0);
            check_value("mem_req_valid_o", 32'(mem_req_valid_o), 32'h0);
        end
        check_value("writeback count", 32'(wb_idx), 32'(wb_exp.size()));
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
llc_pkg.sv
llc_mem_if.sv
llc_fifo.sv
llc_localmem.sv
llc_lookup_way.sv
llc_ctrl.sv
llc_core.sv
tb_llc.sv

// ==== Makefile ====
# Verilator build for the LLC core testbench

SIM    = verilator
FLAGS  = --binary --timing -j 0
TOP    = tb_llc
FLIST  = compile.f
OBJDIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

# a $$fatal in the testbench gives a non-zero exit status
run: compile
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
